// File: Bender.yml
package:
  name: patch_source

sources:
  - rtl/patch_pkg.sv
  - rtl/patch_lfsr.sv
  - rtl/patch_fifo.sv
  - rtl/patch_sequencer.sv
  - rtl/patch_source_top.sv
  - target: simulation
    include_dirs:
      - testbench
    files:
      - testbench/tb_patch_source.sv

// File: rtl/patch_fifo.sv
`timescale 1ns/1ps

module patch_fifo #(
  parameter int depth = 16
) (
  input  logic                   clk_200,
  input  logic                   rst_n,
  input  logic                   wr_en,
  input  patch_pkg::patch_rec_t  din,
  input  logic                   rd_en,
  output patch_pkg::patch_rec_t  dout,
  output logic                   full,
  output logic                   empty
);

  import patch_pkg::*;

  localparam int ptr_w = $clog2(depth);

  typedef logic [ptr_w-1:0] ptr_t;
  typedef logic [ptr_w:0] count_t;

  patch_rec_t mem [depth];
  ptr_t       wr_ptr;
  ptr_t       rd_ptr;
  count_t     count;
  logic       do_wr;
  logic       do_rd;

  assign full  = (count == count_t'(depth));
  assign empty = (count == '0);

  assign do_wr = wr_en && !full;   // Writes into a full buffer are dropped
  assign do_rd = rd_en && !empty;  // Pop on empty ignored

  always_ff @(posedge clk_200) begin
    if (do_wr) begin
      mem[wr_ptr] <= din;
    end
  end

  always_ff @(posedge clk_200 or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_wr) begin
        wr_ptr <= wr_ptr + 1'b1;  // Wraps, depth is a power of two
      end
      if (do_rd) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({do_wr, do_rd})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // Head word straight from storage, valid while not empty
  assign dout = mem[rd_ptr];

endmodule

// File: rtl/patch_lfsr.sv
`timescale 1ns/1ps

module patch_lfsr (
  input  logic               clk_200,
  input  logic               rst_n,
  input  logic               load,
  input  logic               step,
  input  patch_pkg::lfsr_t   seed,
  output patch_pkg::lfsr_t   value
);

  import patch_pkg::*;

  lfsr_t state_q;
  lfsr_t state_next;
  logic  feedback;

  // XNOR taps 12,11,10,4 give the full 4095 period
  assign feedback = ~(state_q[11] ^ state_q[10] ^ state_q[9] ^ state_q[3]);

  always_comb begin
    state_next = state_q;
    if (load) begin
      state_next = seed;  // Load wins over step
    end else if (step) begin
      state_next = {state_q[LFSR_W-2:0], feedback};
    end
  end

  // All zeros is a valid XNOR state, so reset to 0 is safe
  always_ff @(posedge clk_200 or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= '0;
    end else begin
      state_q <= state_next;
    end
  end

  assign value = state_q;

endmodule

// File: rtl/patch_pkg.sv
package patch_pkg;

  localparam int PATCH_NUM_W = 20;
  localparam int LFSR_W = 12;
  localparam int FRAME_POS_W = 20;

  typedef logic [PATCH_NUM_W-1:0] patch_num_t;  // All ones marks start of frame
  typedef logic [LFSR_W-1:0] lfsr_t;
  typedef logic [FRAME_POS_W-1:0] frame_pos_t;  // Low 12 bits hold the block counter

  typedef struct packed {
    patch_num_t patch_num;
    frame_pos_t frame_pos;
  } patch_rec_t;

  typedef enum logic [1:0] {
    SEQ_ERROR      = 2'd0,
    SEQ_INIT       = 2'd1,
    SEQ_INTERFRAME = 2'd2,
    SEQ_INTRAFRAME = 2'd3
  } seq_state_t;

  // Maximal length of a 12-bit LFSR, also the offset step per block
  localparam int LFSR_PERIOD = 4095;

  localparam frame_pos_t SOF_POS = frame_pos_t'(1);

  localparam int N_CAM_MAX = 3;

  // One seed per camera so each stream gets its own scrambled order
  localparam lfsr_t LFSR_SEED [N_CAM_MAX] = '{
    lfsr_t'(512),
    lfsr_t'(1024),
    lfsr_t'(2048)
  };

endpackage

// File: rtl/patch_sequencer.sv
`timescale 1ns/1ps

module patch_sequencer #(
  parameter int n_cam   = 3,
  parameter int n_patch = 8190
) (
  input  logic                   clk_200,
  input  logic                   rst_n,
  input  logic                   app_ready,
  input  patch_pkg::lfsr_t       lfsr_value [n_cam],
  input  logic                   fifo_full [n_cam],
  output logic                   lfsr_load,
  output logic                   lfsr_step,
  output logic                   wr_en [n_cam],
  output patch_pkg::patch_rec_t  wr_rec [n_cam],
  output logic                   gen_error
);

  import patch_pkg::*;

  // Frame ends once offset passes n_patch - 4096
  localparam int last_offset = n_patch - LFSR_PERIOD - 1;

  seq_state_t state_q;
  seq_state_t state_d;
  logic [1:0] ready_sync;
  logic       ready_s;
  lfsr_t      ctr_q;
  lfsr_t      ctr_d;
  patch_num_t offset_q;
  patch_num_t offset_d;
  logic       any_full;
  logic       block_end;
  logic       frame_end;

  logic [PATCH_NUM_W:0] cam_sum [n_cam];  // One extra bit so the range check cannot wrap
  logic                 in_range [n_cam];
  patch_rec_t           cam_rec [n_cam];

  // Ready comes from another block
  always_ff @(posedge clk_200 or negedge rst_n) begin
    if (!rst_n) begin
      ready_sync <= 2'b00;
    end else begin
      ready_sync <= {ready_sync[0], app_ready};
    end
  end

  assign ready_s = ready_sync[1];

  always_comb begin
    any_full = 1'b0;
    for (int c = 0; c < n_cam; c++) begin
      any_full = any_full | fifo_full[c];
    end
  end

  // Per-camera record from scrambled index plus block offset
  always_comb begin
    for (int c = 0; c < n_cam; c++) begin
      cam_sum[c]            = {1'b0, offset_q} + (PATCH_NUM_W + 1)'(lfsr_value[c]);
      in_range[c]           = cam_sum[c] < (PATCH_NUM_W + 1)'(n_patch);
      cam_rec[c].patch_num  = cam_sum[c][PATCH_NUM_W-1:0];
      cam_rec[c].frame_pos  = frame_pos_t'(ctr_q);
    end
  end

  assign block_end = (ctr_q == lfsr_t'(LFSR_PERIOD - 1));
  assign frame_end = int'(offset_q) > last_offset;

  always_comb begin
    state_d   = state_q;
    ctr_d     = ctr_q;
    offset_d  = offset_q;
    lfsr_load = 1'b0;
    lfsr_step = 1'b0;
    for (int c = 0; c < n_cam; c++) begin
      wr_en[c]  = 1'b0;
      wr_rec[c] = cam_rec[c];
    end

    case (state_q)
      SEQ_INIT: begin
        if (ready_s) begin
          lfsr_load = 1'b1;
          ctr_d     = '0;
          state_d   = SEQ_INTERFRAME;
        end
      end

      SEQ_INTERFRAME: begin
        if (any_full) begin
          state_d = SEQ_ERROR;
        end else begin
          for (int c = 0; c < n_cam; c++) begin
            wr_en[c]            = 1'b1;
            wr_rec[c].patch_num = '1;  // SOF marker
            wr_rec[c].frame_pos = SOF_POS;
          end
          offset_d = '0;
          ctr_d    = '0;
          state_d  = SEQ_INTRAFRAME;
        end
      end

      SEQ_INTRAFRAME: begin
        if (any_full || !ready_s) begin
          state_d = SEQ_ERROR;  // No stall, overflow or lost ready is fatal
        end else begin
          for (int c = 0; c < n_cam; c++) begin
            wr_en[c] = in_range[c];
          end
          if (block_end) begin
            // Sequence is back at the seed here anyway
            lfsr_load = 1'b1;
            ctr_d     = '0;
            if (frame_end) begin
              state_d = SEQ_INTERFRAME;
            end else begin
              offset_d = offset_q + patch_num_t'(LFSR_PERIOD);
            end
          end else begin
            lfsr_step = 1'b1;
            ctr_d     = ctr_q + 1'b1;
          end
        end
      end

      default: begin
        state_d = SEQ_ERROR;  // Sticky until reset
      end
    endcase
  end

  always_ff @(posedge clk_200 or negedge rst_n) begin
    if (!rst_n) begin
      state_q  <= SEQ_INIT;
      ctr_q    <= '0;
      offset_q <= '0;
    end else begin
      state_q  <= state_d;
      ctr_q    <= ctr_d;
      offset_q <= offset_d;
    end
  end

  assign gen_error = (state_q == SEQ_ERROR);

endmodule

// File: rtl/patch_source_top.sv
`timescale 1ns/1ps

module patch_source_top #(
  parameter int n_cam      = 3,
  parameter int n_patch    = 8190,
  parameter int fifo_depth = 16
) (
  input  logic                   clk_200,
  input  logic                   rst_n,
  input  logic                   app_ready,
  output logic                   rec_valid [n_cam],
  input  logic                   rec_pop [n_cam],
  output patch_pkg::patch_rec_t  rec [n_cam],
  output logic                   gen_error
);

  import patch_pkg::*;

  logic       lfsr_load;
  logic       lfsr_step;
  lfsr_t      lfsr_value [n_cam];
  logic       fifo_full [n_cam];
  logic       fifo_empty [n_cam];
  logic       wr_en [n_cam];
  patch_rec_t wr_rec [n_cam];

  patch_sequencer #(
    .n_cam   (n_cam),
    .n_patch (n_patch)
  ) u_sequencer (
    .clk_200    (clk_200),
    .rst_n      (rst_n),
    .app_ready  (app_ready),
    .lfsr_value (lfsr_value),
    .fifo_full  (fifo_full),
    .lfsr_load  (lfsr_load),
    .lfsr_step  (lfsr_step),
    .wr_en      (wr_en),
    .wr_rec     (wr_rec),
    .gen_error  (gen_error)
  );

  for (genvar c = 0; c < n_cam; c++) begin : g_cam
    patch_lfsr u_lfsr (
      .clk_200 (clk_200),
      .rst_n   (rst_n),
      .load    (lfsr_load),
      .step    (lfsr_step),
      .seed    (LFSR_SEED[c]),  // Own seed per camera
      .value   (lfsr_value[c])
    );

    patch_fifo #(
      .depth (fifo_depth)
    ) u_fifo (
      .clk_200 (clk_200),
      .rst_n   (rst_n),
      .wr_en   (wr_en[c]),
      .din     (wr_rec[c]),
      .rd_en   (rec_pop[c]),
      .dout    (rec[c]),
      .full    (fifo_full[c]),
      .empty   (fifo_empty[c])
    );

    assign rec_valid[c] = !fifo_empty[c];
  end

endmodule

// File: sim.f
+incdir+testbench
rtl/patch_pkg.sv
rtl/patch_lfsr.sv
rtl/patch_fifo.sv
rtl/patch_sequencer.sv
rtl/patch_source_top.sv
testbench/tb_patch_source.sv

// File: testbench/patch_ref_model.svh
`ifndef PATCH_REF_MODEL_SVH
`define PATCH_REF_MODEL_SVH

lfsr_t ref_lfsr [N_CAM];
int    ref_ctr [N_CAM];
int    ref_offset [N_CAM];
int    ref_blocks [N_CAM];    // Blocks walked since reset
bit    ref_at_sof [N_CAM];

function automatic lfsr_t lfsr_advance(input lfsr_t v);
  return {v[10:0], ~(v[11] ^ v[10] ^ v[9] ^ v[3])};  // Shift left, XNOR of 11,10,9,3
endfunction

function automatic void reset_model(input int cam);
  ref_lfsr[cam]   = LFSR_SEED[cam];
  ref_ctr[cam]    = 0;
  ref_offset[cam] = 0;
  ref_blocks[cam] = 0;
  ref_at_sof[cam] = 1'b1;
endfunction

// One slot of the block walk, whether or not it produced a record
function automatic void advance_slot(input int cam);
  if (ref_ctr[cam] == LFSR_PERIOD - 1) begin
    ref_ctr[cam]  = 0;
    ref_lfsr[cam] = LFSR_SEED[cam];
    ref_blocks[cam]++;
    if (ref_offset[cam] > N_PATCH - 4096) begin
      ref_at_sof[cam] = 1'b1;  // Last block of the frame
    end else begin
      ref_offset[cam] += LFSR_PERIOD;
    end
  end else begin
    ref_ctr[cam]++;
    ref_lfsr[cam] = lfsr_advance(ref_lfsr[cam]);
  end
endfunction

function automatic patch_rec_t next_expected(input int cam);
  patch_rec_t r;
  int         num;
  bit         found;
  r     = '0;
  found = 1'b0;
  while (!found) begin
    if (ref_at_sof[cam]) begin
      ref_at_sof[cam] = 1'b0;
      ref_offset[cam] = 0;
      r.patch_num     = '1;
      r.frame_pos     = SOF_POS;
      found           = 1'b1;
    end else begin
      num = ref_offset[cam] + int'(ref_lfsr[cam]);
      if (num < N_PATCH) begin  // Out of range numbers are never written
        r.patch_num = patch_num_t'(num);
        r.frame_pos = frame_pos_t'(ref_ctr[cam]);
        found       = 1'b1;
      end
      advance_slot(cam);
    end
  end
  return r;
endfunction

`endif

// File: testbench/tb_patch_source.sv
`timescale 1ns/1ps

module tb_patch_source;

  import patch_pkg::*;

  localparam int N_CAM      = 3;
  localparam int N_PATCH    = 8190;
  localparam int FIFO_DEPTH = 16;
  localparam int WAIT_LIMIT = 20000;  // A frame takes about 8200 cycles

  logic       clk_200;
  logic       rst_n;
  logic       app_ready;
  logic       rec_valid [N_CAM];
  logic       rec_pop [N_CAM];
  patch_rec_t rec [N_CAM];
  logic       gen_error;

  logic drain_en [N_CAM];
  int   rec_count [N_CAM];  // Records popped since reset
  int   check_count;
  int   error_count;
  int   timeout_count;

  `include "patch_ref_model.svh"

  patch_source_top #(
    .n_cam      (N_CAM),
    .n_patch    (N_PATCH),
    .fifo_depth (FIFO_DEPTH)
  ) DUT (
    .clk_200   (clk_200),
    .rst_n     (rst_n),
    .app_ready (app_ready),
    .rec_valid (rec_valid),
    .rec_pop   (rec_pop),
    .rec       (rec),
    .gen_error (gen_error)
  );

  initial begin
    clk_200 = 1'b0;
    forever #5 clk_200 = ~clk_200;
  end

  task automatic compare_rec(input patch_rec_t got, input patch_rec_t want, input string what);
    check_count++;
    if (got !== want) begin
      error_count++;
      $display("[ERROR] %0t ns %s: got %05h/%05h, expected %05h/%05h", $time, what,
               got.patch_num, got.frame_pos, want.patch_num, want.frame_pos);
    end
  endtask

  task automatic compare_flag(input logic got, input logic want, input string what);
    check_count++;
    if (got !== want) begin
      error_count++;
      $display("[ERROR] %0t ns %s: got %b, expected %b", $time, what, got, want);
    end
  endtask

  always @(posedge clk_200) begin
    for (int c = 0; c < N_CAM; c++) begin
      rec_pop[c] <= drain_en[c];
    end
  end

  // A pop seen here lands on the next rising edge
  always @(negedge clk_200) begin : check_popped
    patch_rec_t want;
    if (rst_n) begin
      for (int c = 0; c < N_CAM; c++) begin
        if (rec_pop[c] && rec_valid[c]) begin
          want = next_expected(c);
          compare_rec(rec[c], want, $sformatf("camera %0d record %0d", c, rec_count[c]));
          rec_count[c]++;
        end
      end
    end
  end

  function automatic int min_progress(input bit in_blocks);
    int m;
    int v;
    m = 32'h7fff_ffff;
    for (int c = 0; c < N_CAM; c++) begin
      v = in_blocks ? ref_blocks[c] : rec_count[c];
      if (v < m) begin
        m = v;
      end
    end
    return m;
  endfunction

  task automatic wait_progress(input bit in_blocks, input int target, input string what);
    int cycles;
    cycles = 0;
    while (min_progress(in_blocks) < target && cycles < WAIT_LIMIT) begin
      @(negedge clk_200);
      cycles++;
    end
    if (min_progress(in_blocks) < target) begin
      timeout_count++;
      $display("Timeout: no %s after %0d cycles", what, cycles);
    end
  endtask

  task automatic apply_reset();
    @(posedge clk_200);
    rst_n     <= 1'b0;
    app_ready <= 1'b0;
    for (int c = 0; c < N_CAM; c++) begin
      reset_model(c);
      rec_count[c] = 0;
    end
    repeat (4) @(posedge clk_200);
    rst_n <= 1'b1;
  endtask

  task automatic idle_until_ready();
    repeat (200) begin
      @(negedge clk_200);
      for (int c = 0; c < N_CAM; c++) begin
        compare_flag(rec_valid[c], 1'b0, $sformatf("camera %0d rec_valid before ready", c));
      end
      compare_flag(gen_error, 1'b0, "gen_error before ready");
    end
  endtask

  // Two sync flops, one state hop, SOF write, then valid
  task automatic start_of_frame();
    @(posedge clk_200);
    app_ready <= 1'b1;
    for (int n = 1; n <= 5; n++) begin
      @(negedge clk_200);
      for (int c = 0; c < N_CAM; c++) begin
        compare_flag(rec_valid[c], n == 5, $sformatf("camera %0d rec_valid at cycle %0d", c, n));
      end
    end
    wait_progress(1'b0, 1, "SOF record");
  endtask

  task automatic scrambled_order();
    wait_progress(1'b1, 2, "end of the first frame");
    compare_flag(gen_error, 1'b0, "gen_error after first frame");
  endtask

  task automatic frame_repeat();
    wait_progress(1'b1, 3, "first block of the second frame");
  endtask

  task automatic back_pressure_error();
    int cycles;
    repeat (100 + $urandom % 200) @(posedge clk_200);
    drain_en[1] <= 1'b0;
    cycles = 0;
    while (!gen_error && cycles < FIFO_DEPTH + 4) begin
      @(negedge clk_200);
      cycles++;
    end
    compare_flag(gen_error, 1'b1, "gen_error after camera 1 stalls");
    repeat (50) begin
      @(negedge clk_200);
      compare_flag(gen_error, 1'b1, "gen_error held after overflow");
    end
    @(posedge clk_200);
    drain_en[1] <= 1'b1;
    cycles = 0;
    while (rec_valid[1] && cycles < FIFO_DEPTH + 4) begin
      @(negedge clk_200);
      cycles++;
    end
    compare_flag(rec_valid[1], 1'b0, "camera 1 empty after its buffered records");
    repeat (50) begin
      @(negedge clk_200);
      for (int c = 0; c < N_CAM; c++) begin
        compare_flag(rec_valid[c], 1'b0, $sformatf("camera %0d new record after error", c));
      end
    end
  endtask

  task automatic ready_loss();
    int cycles;
    apply_reset();
    @(posedge clk_200);
    app_ready <= 1'b1;
    wait_progress(1'b0, 2000, "mid-frame records after reset");
    @(posedge clk_200);
    app_ready <= 1'b0;
    cycles = 0;
    while (!gen_error && cycles < 4) begin
      @(negedge clk_200);
      cycles++;
    end
    compare_flag(gen_error, 1'b1, "gen_error after ready loss");
    compare_flag(DUT.g_cam[0].u_fifo.full, 1'b0, "camera 0 FIFO full at ready loss");
    compare_flag(DUT.g_cam[1].u_fifo.full, 1'b0, "camera 1 FIFO full at ready loss");
    compare_flag(DUT.g_cam[2].u_fifo.full, 1'b0, "camera 2 FIFO full at ready loss");
    repeat (20) begin
      @(negedge clk_200);
      compare_flag(gen_error, 1'b1, "gen_error held after ready loss");
    end
  endtask

  initial begin
    void'($urandom(32'h1811));
    rst_n         = 1'b0;
    app_ready     = 1'b0;
    check_count   = 0;
    error_count   = 0;
    timeout_count = 0;
    for (int c = 0; c < N_CAM; c++) begin
      rec_pop[c]   = 1'b0;
      drain_en[c]  = 1'b1;
      rec_count[c] = 0;
      reset_model(c);
    end
    apply_reset();
    idle_until_ready();
    start_of_frame();
    scrambled_order();
    frame_repeat();
    back_pressure_error();
    ready_loss();
    $display("Checks: %0d, errors: %0d, timeouts: %0d", check_count, error_count, timeout_count);
    if (error_count == 0 && timeout_count == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule
